/* verilog/fas_defs.svh */
// Widths and constants shared by RTL and testbench; FIR and twiddle values are Q16 fixed point
`ifndef FAS_DEFS_SVH
`define FAS_DEFS_SVH

////////////////////
// Widths and sizes
`define FAS_SAMPLE_W   16
`define FAS_COEF_W     20
`define FAS_TAPS       32
`define FAS_FRAME_N    16
`define FAS_LANE_W     24
`define FAS_FRAC_SHIFT 16
`define FAS_OUT_SHIFT  4

////////////////////
// FIR coefficients, first half only since tap 31-i equals tap i
`define FAS_FIR_C0  20'shFFF9E
`define FAS_FIR_C1  20'shFFF86
`define FAS_FIR_C2  20'shFFFA7
`define FAS_FIR_C3  20'sh0003B
`define FAS_FIR_C4  20'sh0014B
`define FAS_FIR_C5  20'sh0024A
`define FAS_FIR_C6  20'sh00222
`define FAS_FIR_C7  20'shFFFE4
`define FAS_FIR_C8  20'shFFBC5
`define FAS_FIR_C9  20'shFF7CA
`define FAS_FIR_C10 20'shFF74E
`define FAS_FIR_C11 20'shFFD74
`define FAS_FIR_C12 20'sh00B1A
`define FAS_FIR_C13 20'sh01DAC
`define FAS_FIR_C14 20'sh02F9E
`define FAS_FIR_C15 20'sh03AA9  // Center taps, largest weight

////////////////////
// Twiddles W16^k = cos - j*sin
`define FAS_TW_RE0 65536
`define FAS_TW_RE1 60547
`define FAS_TW_RE2 46340
`define FAS_TW_RE3 25079
`define FAS_TW_RE4 0
`define FAS_TW_RE5 (-25079)
`define FAS_TW_RE6 (-46340)
`define FAS_TW_RE7 (-60547)
`define FAS_TW_IM0 0
`define FAS_TW_IM1 (-25079)
`define FAS_TW_IM2 (-46340)
`define FAS_TW_IM3 (-60547)
`define FAS_TW_IM4 (-65536)
`define FAS_TW_IM5 (-60547)
`define FAS_TW_IM6 (-46340)
`define FAS_TW_IM7 (-25079)

`endif

/* verilog/fas_pkg.sv */
// Data types of the spectrum front end; widths come from the shared defines header
`default_nettype none

`include "fas_defs.svh"

package fas_pkg;

  ////////////////////
  // Scalar types
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;  // Q8.8 sample
  typedef logic signed [`FAS_COEF_W-1:0]   coef_t;    // Q16 FIR coefficient
  typedef logic signed [`FAS_LANE_W-1:0]   lane_t;    // FFT internal value

  ////////////////////
  // FFT internal lanes
  typedef struct packed {
    lane_t re;
    lane_t im;
  } cplx_lane_t;

  typedef cplx_lane_t [`FAS_FRAME_N-1:0] lane_vec_t;  // One full stage vector

  // Frame from the buffer, slot 0 is the oldest sample
  typedef sample_t [`FAS_FRAME_N-1:0] frame_t;

  ////////////////////
  // Spectrum output
  typedef struct packed {
    sample_t re;
    sample_t im;
  } bin_t;

  typedef bin_t [`FAS_FRAME_N-1:0] spectrum_t;  // Natural bin order

endpackage

`default_nettype wire

/* verilog/fir_filter.sv */
// Symmetric 32-tap FIR, output valid only after 32 unbroken samples; any gap restarts warm-up
`timescale 1ns/1ps
`default_nettype none

`include "fas_defs.svh"

module fir_filter (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            data_valid,
  input  wire fas_pkg::sample_t data,
  output      logic            fir_valid,
  output      fas_pkg::sample_t fir_d
);

  localparam int HALF  = `FAS_TAPS / 2;
  localparam int RUN_W = $clog2(`FAS_TAPS);
  localparam int PRE_W = `FAS_SAMPLE_W + 1;
  localparam int ACC_W = PRE_W + `FAS_COEF_W + $clog2(HALF);

  localparam logic [RUN_W-1:0]       RUN_MAX    = RUN_W'(`FAS_TAPS - 1);
  localparam logic signed [ACC_W-1:0] TRUNC_BIAS = ACC_W'((1 << `FAS_FRAC_SHIFT) - 1);

  localparam fas_pkg::coef_t FIR_C [HALF] = '{
    `FAS_FIR_C0,  `FAS_FIR_C1,  `FAS_FIR_C2,  `FAS_FIR_C3,
    `FAS_FIR_C4,  `FAS_FIR_C5,  `FAS_FIR_C6,  `FAS_FIR_C7,
    `FAS_FIR_C8,  `FAS_FIR_C9,  `FAS_FIR_C10, `FAS_FIR_C11,
    `FAS_FIR_C12, `FAS_FIR_C13, `FAS_FIR_C14, `FAS_FIR_C15
  };

  fas_pkg::sample_t          hist [`FAS_TAPS-1];  // x[n-1] at index 0
  fas_pkg::sample_t          win  [`FAS_TAPS];    // x[n-k] at index k
  logic signed [PRE_W-1:0]   pre  [HALF];
  logic signed [ACC_W-1:0]   acc;
  logic signed [ACC_W-1:0]   acc_adj;
  logic [RUN_W-1:0]          run_cnt;             // Earlier samples in this run, saturating

  ////////////////////
  // Symmetric sum over the live sample plus history
  always_comb begin
    win[0] = data;
    for (int k = 1; k < `FAS_TAPS; k++) begin
      win[k] = hist[k-1];
    end
  end

  always_comb begin
    acc = '0;
    for (int i = 0; i < HALF; i++) begin
      pre[i] = win[i] + win[`FAS_TAPS-1-i];  // Shared coefficient pair
      acc    = acc + pre[i] * FIR_C[i];
    end
    // Bias negative sums so the shift truncates toward zero
    acc_adj = acc[ACC_W-1] ? acc + TRUNC_BIAS : acc;
  end

  ////////////////////
  // Delay line, run counter and output register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hist      <= '{default: '0};
      run_cnt   <= '0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else if (data_valid) begin
      hist[0] <= data;
      for (int k = 1; k < `FAS_TAPS-1; k++) begin
        hist[k] <= hist[k-1];
      end
      if (run_cnt != RUN_MAX) begin
        run_cnt <= run_cnt + 1'b1;
      end
      fir_valid <= (run_cnt == RUN_MAX);  // 32nd sample or later
      fir_d     <= acc_adj[`FAS_FRAC_SHIFT +: `FAS_SAMPLE_W];
    end else begin
      run_cnt   <= '0;  // Gap restarts warm-up
      fir_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/frame_buffer.sv */
// Gathers 16 valid filter samples into one frame; gaps pause the fill but never reset it
`timescale 1ns/1ps
`default_nettype none

`include "fas_defs.svh"

module frame_buffer (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            fir_valid,
  input  wire fas_pkg::sample_t fir_d,
  output      logic            frame_valid,
  output      fas_pkg::frame_t frame
);

  localparam int CNT_W = $clog2(`FAS_FRAME_N);
  localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(`FAS_FRAME_N - 1);

  logic [CNT_W-1:0] wr_cnt;     // Wraps after the last slot
  fas_pkg::frame_t  slots;
  fas_pkg::frame_t  slots_nxt;  // Slots including this beat

  always_comb begin
    slots_nxt         = slots;
    slots_nxt[wr_cnt] = fir_d;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_cnt      <= '0;
      slots       <= '0;
      frame       <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;  // One-cycle pulse
      if (fir_valid) begin
        slots  <= slots_nxt;
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_cnt == LAST_SLOT) begin
          frame       <= slots_nxt;
          frame_valid <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/fft_stage.sv */
// One registered radix-2 DIF stage of the 16-point FFT; SPAN must be 8, 4, 2 or 1, sums wrap
`timescale 1ns/1ps
`default_nettype none

`include "fas_defs.svh"

module fft_stage #(
  parameter int SPAN = 8
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               in_valid,
  input  wire fas_pkg::lane_vec_t in_lanes,
  output      logic               out_valid,
  output      fas_pkg::lane_vec_t out_lanes
);

  localparam int HALF   = `FAS_FRAME_N / 2;       // Butterflies per stage
  localparam int TW_W   = `FAS_FRAC_SHIFT + 2;    // Holds +-1.0 in Q16
  localparam int PROD_W = `FAS_LANE_W + TW_W + 1;
  localparam int TW_STEP = HALF / SPAN;

  localparam int TW_RE [HALF] = '{
    `FAS_TW_RE0, `FAS_TW_RE1, `FAS_TW_RE2, `FAS_TW_RE3,
    `FAS_TW_RE4, `FAS_TW_RE5, `FAS_TW_RE6, `FAS_TW_RE7
  };
  localparam int TW_IM [HALF] = '{
    `FAS_TW_IM0, `FAS_TW_IM1, `FAS_TW_IM2, `FAS_TW_IM3,
    `FAS_TW_IM4, `FAS_TW_IM5, `FAS_TW_IM6, `FAS_TW_IM7
  };

  fas_pkg::lane_vec_t lanes_nxt;

  ////////////////////
  // Butterflies
  always_comb begin : bfly
    int                   a;
    int                   b;
    int                   t;
    fas_pkg::cplx_lane_t  x;
    fas_pkg::cplx_lane_t  y;
    fas_pkg::lane_t       d_re;
    fas_pkg::lane_t       d_im;
    logic signed [PROD_W-1:0] p_re;
    logic signed [PROD_W-1:0] p_im;
    lanes_nxt = '0;
    for (int bf = 0; bf < HALF; bf++) begin
      a = (bf / SPAN) * 2 * SPAN + (bf % SPAN);  // Group base plus position
      b = a + SPAN;
      t = (bf % SPAN) * TW_STEP;
      x = in_lanes[a];
      y = in_lanes[b];
      lanes_nxt[a].re = x.re + y.re;
      lanes_nxt[a].im = x.im + y.im;
      d_re = x.re - y.re;
      d_im = x.im - y.im;
      p_re = d_re * TW_RE[t] - d_im * TW_IM[t];
      p_im = d_re * TW_IM[t] + d_im * TW_RE[t];
      // Bit slice is the arithmetic Q16 shift cut to lane width
      lanes_nxt[b].re = p_re[`FAS_FRAC_SHIFT +: `FAS_LANE_W];
      lanes_nxt[b].im = p_im[`FAS_FRAC_SHIFT +: `FAS_LANE_W];
    end
  end

  ////////////////////
  // Stage register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_lanes <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        out_lanes <= lanes_nxt;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/fft16.sv */
// Pipelined 16-point DIF FFT of a real frame, 4-cycle latency, bins scaled down by 16
`timescale 1ns/1ps
`default_nettype none

`include "fas_defs.svh"

module fft16 (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               frame_valid,
  input  wire fas_pkg::frame_t    frame,
  output      logic               fft_valid,
  output      fas_pkg::spectrum_t fft_d
);

  localparam int N_STAGES = $clog2(`FAS_FRAME_N);

  fas_pkg::lane_vec_t lanes [N_STAGES+1];  // Stage inputs, last entry is the result
  logic               valid [N_STAGES+1];

  function automatic logic [N_STAGES-1:0] bit_rev(input logic [N_STAGES-1:0] idx);
    logic [N_STAGES-1:0] r;
    for (int i = 0; i < N_STAGES; i++) begin
      r[i] = idx[N_STAGES-1-i];
    end
    return r;
  endfunction

  ////////////////////
  // Real frame into complex lanes
  always_comb begin
    valid[0] = frame_valid;
    for (int i = 0; i < `FAS_FRAME_N; i++) begin
      lanes[0][i].re = fas_pkg::lane_t'(frame[i]);  // Sign extension
      lanes[0][i].im = '0;
    end
  end

  for (genvar s = 0; s < N_STAGES; s++) begin : g_stage
    fft_stage #(
      .SPAN ((`FAS_FRAME_N / 2) >> s)
    ) fft_stage_i (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (valid[s]),
      .in_lanes  (lanes[s]),
      .out_valid (valid[s+1]),
      .out_lanes (lanes[s+1])
    );
  end

  ////////////////////
  // Natural order and output scaling
  always_comb begin
    fft_valid = valid[N_STAGES];
    for (int m = 0; m < `FAS_FRAME_N; m++) begin
      fft_d[m].re = lanes[N_STAGES][bit_rev(N_STAGES'(m))].re[`FAS_OUT_SHIFT +: `FAS_SAMPLE_W];
      fft_d[m].im = lanes[N_STAGES][bit_rev(N_STAGES'(m))].im[`FAS_OUT_SHIFT +: `FAS_SAMPLE_W];
    end
  end

endmodule

`default_nettype wire

/* verilog/fas_top.sv */
// Stream front end FIR, framer and FFT; no back-pressure, every valid beat is taken
`timescale 1ns/1ps
`default_nettype none

module fas_top (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               data_valid,
  input  wire fas_pkg::sample_t   data,
  output      logic               fir_valid,
  output      fas_pkg::sample_t   fir_d,
  output      logic               fft_valid,
  output      fas_pkg::spectrum_t fft_d
);

  logic            frame_valid;
  fas_pkg::frame_t frame;

  fir_filter fir_filter_i (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  frame_buffer frame_buffer_i (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  fft16 fft16_i (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame       (frame),
    .fft_valid   (fft_valid),
    .fft_d       (fft_d)
  );

endmodule

`default_nettype wire

/* tb/fas_model.svh */
// Reference model for tb_fas, built from the filter, framing and FFT rules; include inside the module
`ifndef FAS_MODEL_SVH
`define FAS_MODEL_SVH

localparam longint FRAC_ONE = 64'sd1 << `FAS_FRAC_SHIFT;

localparam fas_pkg::coef_t FIR_HALF_COEF [`FAS_TAPS/2] = '{
  `FAS_FIR_C0,  `FAS_FIR_C1,  `FAS_FIR_C2,  `FAS_FIR_C3,
  `FAS_FIR_C4,  `FAS_FIR_C5,  `FAS_FIR_C6,  `FAS_FIR_C7,
  `FAS_FIR_C8,  `FAS_FIR_C9,  `FAS_FIR_C10, `FAS_FIR_C11,
  `FAS_FIR_C12, `FAS_FIR_C13, `FAS_FIR_C14, `FAS_FIR_C15
};
localparam longint TW_RE_Q16 [`FAS_FRAME_N/2] = '{
  `FAS_TW_RE0, `FAS_TW_RE1, `FAS_TW_RE2, `FAS_TW_RE3,
  `FAS_TW_RE4, `FAS_TW_RE5, `FAS_TW_RE6, `FAS_TW_RE7
};
localparam longint TW_IM_Q16 [`FAS_FRAME_N/2] = '{
  `FAS_TW_IM0, `FAS_TW_IM1, `FAS_TW_IM2, `FAS_TW_IM3,
  `FAS_TW_IM4, `FAS_TW_IM5, `FAS_TW_IM6, `FAS_TW_IM7
};

fas_pkg::sample_t model_line [`FAS_TAPS];  // x[n-k] at index k
int               model_run;               // Unbroken run length, stops at the tap count
fas_pkg::sample_t model_fill [$];          // Filtered samples of the open frame

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;  // Full period mod 2^32
endfunction

function automatic longint wrap_lane(input longint v);
  fas_pkg::lane_t l;
  l = fas_pkg::lane_t'(v);  // Keep the low lane bits
  return longint'(l);
endfunction

function automatic int bit_reverse(input int m);
  return int'({m[0], m[1], m[2], m[3]});  // 16 points, 4 index bits
endfunction

////////////////////
// Filter over a software delay line
task automatic filter_step(input fas_pkg::sample_t x, output logic ok,
                           output fas_pkg::sample_t y);
  longint acc;
  int     h;
  for (int k = `FAS_TAPS - 1; k > 0; k--) begin
    model_line[k] = model_line[k-1];
  end
  model_line[0] = x;
  if (model_run < `FAS_TAPS) begin
    model_run++;
  end
  acc = 0;
  for (int k = 0; k < `FAS_TAPS; k++) begin
    h   = (k < `FAS_TAPS / 2) ? k : `FAS_TAPS - 1 - k;  // Mirror tap
    acc = acc + longint'(model_line[k]) * longint'(FIR_HALF_COEF[h]);
  end
  y  = fas_pkg::sample_t'(acc / FRAC_ONE);  // Division truncates toward zero
  ok = (model_run >= `FAS_TAPS);
endtask

////////////////////
// Fixed-point DIF FFT, butterfly by butterfly
function automatic fas_pkg::spectrum_t fft_reference(input fas_pkg::frame_t f);
  longint             re [`FAS_FRAME_N];
  longint             im [`FAS_FRAME_N];
  longint             dr;
  longint             di;
  int                 a;
  int                 b;
  int                 t;
  fas_pkg::spectrum_t s;
  for (int i = 0; i < `FAS_FRAME_N; i++) begin
    re[i] = longint'(f[i]);
    im[i] = 0;
  end
  for (int span = `FAS_FRAME_N / 2; span >= 1; span = span / 2) begin
    for (int g = 0; g < `FAS_FRAME_N; g = g + 2 * span) begin
      for (int k = 0; k < span; k++) begin
        a     = g + k;
        b     = a + span;
        t     = k * ((`FAS_FRAME_N / 2) / span);
        dr    = wrap_lane(re[a] - re[b]);
        di    = wrap_lane(im[a] - im[b]);
        re[a] = wrap_lane(re[a] + re[b]);
        im[a] = wrap_lane(im[a] + im[b]);
        re[b] = wrap_lane((dr * TW_RE_Q16[t] - di * TW_IM_Q16[t]) >>> `FAS_FRAC_SHIFT);
        im[b] = wrap_lane((dr * TW_IM_Q16[t] + di * TW_RE_Q16[t]) >>> `FAS_FRAC_SHIFT);
      end
    end
  end
  for (int m = 0; m < `FAS_FRAME_N; m++) begin
    s[m].re = fas_pkg::sample_t'(re[bit_reverse(m)] >>> `FAS_OUT_SHIFT);
    s[m].im = fas_pkg::sample_t'(im[bit_reverse(m)] >>> `FAS_OUT_SHIFT);
  end
  return s;
endfunction

// Frame count and spectrum once a frame fills
task automatic frame_collect(input fas_pkg::sample_t y, output logic done,
                             output fas_pkg::spectrum_t spec);
  fas_pkg::frame_t f;
  model_fill.push_back(y);
  done = 1'b0;
  spec = '0;
  if (model_fill.size() == `FAS_FRAME_N) begin
    for (int i = 0; i < `FAS_FRAME_N; i++) begin
      f[i] = model_fill[i];  // Slot 0 oldest
    end
    model_fill.delete();
    spec = fft_reference(f);
    done = 1'b1;
  end
endtask

`endif

/* tb/tb_fas.sv */
// Self-checking testbench for fas_top; fixed-seed LCG stimulus, run bounded by a cycle limit
`timescale 1ns/1ps
`default_nettype none

`include "fas_defs.svh"

module tb_fas;

  localparam int CLK_HALF    = 4;     // 8 ns period
  localparam int RST_CYCLES  = 16;
  localparam int E2E_LAT     = 6;     // FIR, frame buffer, four FFT stages
  localparam int STIM_CYCLES = 1038;  // Reset, warm-up, 400 samples, padded frames, 20 frames
  localparam int LIMIT       = 2 * STIM_CYCLES + 100;

  logic               clk;
  logic               rst;
  logic               data_valid;
  fas_pkg::sample_t   data;
  logic               fir_valid;
  fas_pkg::sample_t   fir_d;
  logic               fft_valid;
  fas_pkg::spectrum_t fft_d;

  logic [31:0]        rng;
  int                 cyc;          // Falling edges since time zero
  int                 wd_cycles;
  int                 errors;
  int                 checks;
  int                 n_tests;
  int                 n_failed;
  int                 test_err0;
  int                 fft_seen;
  int                 frames_done;
  string              test_name;
  logic               pend_fv;      // Model expects fir_valid after the next edge
  fas_pkg::sample_t   pend_d;
  fas_pkg::spectrum_t exp_spec [$];
  int                 exp_due [$];  // Cycle at which each spectrum shows

  `include "fas_model.svh"

  fas_top fas_top_i (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d),
    .fft_valid  (fft_valid),
    .fft_d      (fft_d)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  initial begin
    wd_cycles = 0;
    while (wd_cycles < LIMIT) begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////
  // Checks
  task automatic note_error(input string msg);
    errors++;
    $display("%s: %s", test_name, msg);
  endtask

  task automatic check_sample(input string what, input fas_pkg::sample_t exp,
                              input fas_pkg::sample_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bin(input int idx, input fas_pkg::bin_t exp, input fas_pkg::bin_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s bin %0d: expected (%0d, %0d), actual (%0d, %0d)",
               test_name, idx, exp.re, exp.im, act.re, act.im);
    end
  endtask

  // Outputs here reflect the rising edge just before this falling edge
  task automatic check_outputs();
    fas_pkg::spectrum_t spec;
    int                 due;
    if (pend_fv && !fir_valid) begin
      note_error($sformatf("fir_valid missing at cycle %0d", cyc));
    end else if (pend_fv) begin
      check_sample("fir_d", pend_d, fir_d);
    end else if (fir_valid) begin
      note_error($sformatf("fir_valid high at cycle %0d without a warm filter", cyc));
    end
    if (fft_valid) begin
      fft_seen++;
      if (exp_due.size() == 0) begin
        note_error($sformatf("fft_valid at cycle %0d with no completed frame", cyc));
      end else begin
        spec = exp_spec.pop_front();
        due  = exp_due.pop_front();
        if (due != cyc) begin
          note_error($sformatf("fft_valid at cycle %0d, due at cycle %0d", cyc, due));
        end
        for (int m = 0; m < `FAS_FRAME_N; m++) begin
          check_bin(m, spec[m], fft_d[m]);
        end
      end
    end else if (exp_due.size() != 0 && exp_due[0] <= cyc) begin
      note_error($sformatf("no fft_valid for the frame due at cycle %0d", exp_due[0]));
      spec = exp_spec.pop_front();
      due  = exp_due.pop_front();
    end
  endtask

  ////////////////////
  // Stimulus
  task automatic drive(input logic v, input fas_pkg::sample_t x);
    fas_pkg::sample_t   y;
    fas_pkg::spectrum_t spec;
    logic               ok;
    logic               done;
    @(negedge clk);
    cyc++;
    check_outputs();
    data_valid = v;
    data       = x;
    pend_fv    = 1'b0;
    if (v) begin
      filter_step(x, ok, y);
      pend_fv = ok;
      pend_d  = y;
      if (ok) begin
        frame_collect(y, done, spec);
        if (done) begin
          exp_spec.push_back(spec);
          exp_due.push_back(cyc + E2E_LAT);
          frames_done++;
        end
      end
    end else begin
      model_run = 0;  // Gap restarts warm-up
    end
  endtask

  task automatic next_random(input logic extremes, output fas_pkg::sample_t x);
    rng = lcg_next(rng);
    if (extremes && rng[31:29] == 3'd0) begin
      x = 16'sh7fff;
    end else if (extremes && rng[31:29] == 3'd1) begin
      x = 16'sh8000;
    end else begin
      x = fas_pkg::sample_t'(rng[23:8]);
    end
  endtask

  task automatic drain();
    while (exp_due.size() != 0) begin
      drive(1'b0, '0);
    end
    repeat (3) drive(1'b0, '0);  // Room for a stray pulse
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_err0   = errors;
    fft_seen    = 0;
    frames_done = 0;
  endtask

  task automatic end_test();
    n_tests++;
    if (errors == test_err0) begin
      $display("test %s passed", test_name);
    end else begin
      n_failed++;
      $display("test %s failed with %0d errors", test_name, errors - test_err0);
    end
  endtask

  task automatic check_frame_count(input int want);
    if (fft_seen != frames_done || frames_done < want) begin
      note_error($sformatf("%0d fft_valid pulses for %0d completed frames", fft_seen,
                           frames_done));
    end
  endtask

  ////////////////////
  // Test sequence
  initial begin
    fas_pkg::sample_t x;
    int               pad;
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    rng        = 32'hbaaa2dcd;
    cyc        = 0;
    errors     = 0;
    checks     = 0;
    n_tests    = 0;
    n_failed   = 0;
    pend_fv    = 1'b0;
    pend_d     = '0;
    model_line = '{default: '0};
    model_run  = 0;

    begin_test("reset");
    repeat (RST_CYCLES) begin
      @(negedge clk);
      cyc++;
      if (fir_valid !== 1'b0 || fft_valid !== 1'b0) begin
        note_error($sformatf("valid output not low in reset at cycle %0d", cyc));
      end
    end
    rst = 1'b0;
    repeat (4) drive(1'b0, '0);
    end_test();

    begin_test("warmup");
    for (int r = 0; r < 2; r++) begin
      repeat (40) begin
        next_random(1'b0, x);
        drive(1'b1, x);
      end
      drive(1'b0, '0);  // One-cycle gap
    end
    drain();
    end_test();

    begin_test("accuracy");
    repeat (400) begin
      next_random(1'b1, x);
      drive(1'b1, x);
    end
    drain();
    end_test();

    for (int p = 0; p < 3; p++) begin
      case (p)
        0: begin_test("frame_const");
        1: begin_test("frame_alt");
        default: begin_test("frame_rand");
      endcase
      // Pad so the pattern ends on a frame boundary
      pad = (`FAS_FRAME_N - model_fill.size()) % `FAS_FRAME_N;
      for (int i = 0; i < `FAS_TAPS - 1 + `FAS_FRAME_N + pad; i++) begin
        case (p)
          0: x = 16'sh0c80;
          1: x = i[0] ? 16'shd000 : 16'sh3000;
          default: next_random(1'b0, x);
        endcase
        drive(1'b1, x);
      end
      drain();
      check_frame_count(1);
      end_test();
    end

    begin_test("stream");
    repeat (`FAS_TAPS - 1 + 20 * `FAS_FRAME_N) begin
      next_random(1'b0, x);
      drive(1'b1, x);
    end
    drain();
    check_frame_count(20);
    end_test();

    $display("tests run %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_tests - n_failed, n_failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
+incdir+tb
verilog/fas_pkg.sv
verilog/fir_filter.sv
verilog/frame_buffer.sv
verilog/fft_stage.sv
verilog/fft16.sv
verilog/fas_top.sv
tb/tb_fas.sv

/* Makefile */
# Verilator build and run for the spectrum front end testbench
SIM      = verilator
TOP      = tb_fas
FILELIST = all.f
FLAGS    = --binary --timing -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
PASS_MSG = STATUS: PASS

SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = verilog/fas_defs.svh tb/fas_model.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
